// ==== Makefile ====
TOP := tbConfigLoader

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f hw/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing --assert -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== compile.f ====
hw/cfgLoaderPkg.sv
hw/uartRx.sv
hw/frameCtrl.sv
hw/payloadDecode.sv
hw/wordPacker.sv
hw/configLoader.sv
tests/clkGen.sv
tests/tbConfigLoader.sv

// ==== hw/cfgLoaderPkg.sv ====
package cfgLoaderPkg;

    // one received or decoded byte, qualified by a single-cycle strobe
    // the same shape is used on every byte stream of the loader
    typedef struct packed {
        logic       strobe;  // high for exactly one cycle per byte
        logic [7:0] data;    // valid only while strobe is high
    } byteEvt_t;

    // frame layout on the serial line
    //   byte 0..2  sync header 00 AA FF
    //   byte 3     command
    //   byte 4..   payload, ended by line inactivity

    // the three ID bytes, first byte in the top lane
    localparam logic [23:0] SYNC_ID = 24'h00AAFF;

    // accepted command codes, compared against command[6:0]
    localparam logic [6:0] CMD_LOAD_A = 7'd1;
    localparam logic [6:0] CMD_LOAD_B = 7'd2;

    // command bit that selects the payload format
    // set: ASCII-hex pairs, clear: raw binary
    localparam int HEX_MODE_BIT = 7;

    // bytes per output word, packed MSB first
    localparam int WORD_BYTES = 4;

endpackage

// ==== hw/configLoader.sv ====
module configLoader #(
    parameter int ComRate       = 217,   // f_CLK / baud rate
    parameter int TimeoutCycles = 16777  // quiet cycles that end a frame
) (
    input  logic                                   CLK,
    input  logic                                   resetn,
    input  logic                                   Rx,
    output logic [cfgLoaderPkg::WORD_BYTES*8-1:0]  WriteData,
    output logic                                   WriteStrobe,
    output logic                                   ComActive,
    output logic [7:0]                             Command
);

    import cfgLoaderPkg::*;

    byteEvt_t rxByte;    // raw bytes from the line
    byteEvt_t payload;   // bytes of the data phase only
    byteEvt_t dataByte;  // decoded payload bytes
    logic     lineStart;
    logic     hexMode;
    logic     frameStart;

    uartRx #(.ComRate(ComRate)) uRx (
        .CLK       (CLK),
        .resetn    (resetn),
        .Rx        (Rx),
        .rxByte    (rxByte),
        .lineStart (lineStart)
    );

    frameCtrl #(.TimeoutCycles(TimeoutCycles)) uFrame (
        .CLK        (CLK),
        .resetn     (resetn),
        .rxByte     (rxByte),
        .lineStart  (lineStart),
        .payload    (payload),
        .hexMode    (hexMode),
        .frameStart (frameStart),
        .ComActive  (ComActive),
        .Command    (Command)
    );

    payloadDecode uDecode (
        .CLK        (CLK),
        .resetn     (resetn),
        .payload    (payload),
        .hexMode    (hexMode),
        .frameStart (frameStart),
        .dataByte   (dataByte)
    );

    wordPacker uPacker (
        .CLK         (CLK),
        .resetn      (resetn),
        .dataByte    (dataByte),
        .frameStart  (frameStart),
        .WriteData   (WriteData),
        .WriteStrobe (WriteStrobe)
    );

endmodule

// ==== hw/frameCtrl.sv ====
module frameCtrl #(
    parameter int TimeoutCycles = 16777  // idle cycles before a frame is dropped
) (
    input  logic                   CLK,
    input  logic                   resetn,
    input  cfgLoaderPkg::byteEvt_t rxByte,
    input  logic                   lineStart,
    output cfgLoaderPkg::byteEvt_t payload,
    output logic                   hexMode,
    output logic                   frameStart,
    output logic                   ComActive,
    output logic [7:0]             Command
);

    import cfgLoaderPkg::*;

    localparam int ToW = $clog2(TimeoutCycles + 1);
    localparam logic [ToW-1:0] ToLoad = ToW'(TimeoutCycles);

    typedef enum logic [2:0] {
        Idle,
        GetId0,
        GetId1,
        GetId2,
        GetCmd,
        EvalCmd,
        GetData
    } frameState_t;

    frameState_t    state;
    logic [23:0]    idReg;
    logic [7:0]     cmdReg;
    logic [ToW-1:0] toCnt;
    logic           timeout;
    logic           headerOk;

    assign timeout  = (toCnt == '0);
    assign headerOk = (idReg == SYNC_ID) &&
                      (cmdReg[6:0] == CMD_LOAD_A || cmdReg[6:0] == CMD_LOAD_B);

    // inactivity timer, rearmed by every received byte
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            toCnt <= ToLoad;
        end else if (state == Idle || rxByte.strobe) begin
            toCnt <= ToLoad;
        end else if (!timeout) begin
            toCnt <= toCnt - 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (lineStart) state <= GetId0;
                end
                GetId0: begin
                    if (timeout) begin
                        state <= Idle;
                    end else if (rxByte.strobe) begin
                        state <= GetId1;
                    end
                end
                GetId1: begin
                    if (timeout) begin
                        state <= Idle;
                    end else if (rxByte.strobe) begin
                        state <= GetId2;
                    end
                end
                GetId2: begin
                    if (timeout) begin
                        state <= Idle;
                    end else if (rxByte.strobe) begin
                        state <= GetCmd;
                    end
                end
                GetCmd: begin
                    if (timeout) begin
                        state <= Idle;
                    end else if (rxByte.strobe) begin
                        state <= EvalCmd;
                    end
                end
                EvalCmd: begin
                    state <= headerOk ? GetData : Idle;  // single decision cycle
                end
                GetData: begin
                    if (timeout) state <= Idle;  // line went quiet, frame over
                end
                default: state <= Idle;
            endcase
        end
    end

    // first ID byte ends up in [23:16]
    always_ff @(posedge CLK) begin
        if (rxByte.strobe && (state == GetId0 || state == GetId1 || state == GetId2)) begin
            idReg <= {idReg[15:0], rxByte.data};
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            cmdReg <= '0;
        end else if (rxByte.strobe && state == GetCmd) begin
            cmdReg <= rxByte.data;
        end
    end

    assign payload    = '{strobe: rxByte.strobe && (state == GetData), data: rxByte.data};
    assign hexMode    = cmdReg[HEX_MODE_BIT];  // stable until the next command byte
    assign frameStart = (state == EvalCmd) && headerOk;
    assign ComActive  = (state == GetData);
    assign Command    = cmdReg;

endmodule

// ==== hw/payloadDecode.sv ====
module payloadDecode (
    input  logic                   CLK,
    input  logic                   resetn,
    input  cfgLoaderPkg::byteEvt_t payload,
    input  logic                   hexMode,
    input  logic                   frameStart,
    output cfgLoaderPkg::byteEvt_t dataByte
);

    // bit 4 flags a character outside 0-9, A-F, a-f
    function automatic logic [4:0] asciiToNibble(input logic [7:0] ch);
        logic [4:0] code;
        if (ch >= "0" && ch <= "9") begin
            code = {1'b0, ch[3:0]};
        end else if ((ch >= "A" && ch <= "F") || (ch >= "a" && ch <= "f")) begin
            code = {1'b0, ch[3:0] + 4'd9};  // 'A' and 'a' both end in 1
        end else begin
            code = 5'h10;
        end
        return code;
    endfunction

    logic [4:0] charCode;
    logic       charValid;
    logic       haveHigh;  // high nibble waiting for its partner
    logic [3:0] highNib;
    logic       byteStb;
    logic [7:0] byteVal;

    assign charCode  = asciiToNibble(payload.data);
    assign charValid = !charCode[4];

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            haveHigh <= 1'b0;
        end else if (frameStart) begin
            haveHigh <= 1'b0;
        end else if (payload.strobe && hexMode) begin
            if (!charValid) begin
                haveHigh <= 1'b0;  // junk drops a pending half byte
            end else begin
                haveHigh <= !haveHigh;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (payload.strobe && hexMode && charValid && !haveHigh) highNib <= charCode[3:0];
    end

    // one cycle after the binary byte or the second hex character
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            byteStb <= 1'b0;
        end else begin
            byteStb <= payload.strobe && (!hexMode || (charValid && haveHigh));
        end
    end

    always_ff @(posedge CLK) begin
        if (payload.strobe) byteVal <= hexMode ? {highNib, charCode[3:0]} : payload.data;
    end

    assign dataByte = '{strobe: byteStb, data: byteVal};

endmodule

// ==== hw/uartRx.sv ====
module uartRx #(
    parameter int ComRate = 217  // clock cycles per bit
) (
    input  logic                   CLK,
    input  logic                   resetn,
    input  logic                   Rx,
    output cfgLoaderPkg::byteEvt_t rxByte,
    output logic                   lineStart
);

    localparam int CntW = $clog2(ComRate);
    localparam logic [CntW-1:0] FullBit = CntW'(ComRate - 1);
    localparam logic [CntW-1:0] HalfBit = CntW'(ComRate / 2 - 1);

    typedef enum logic [1:0] {
        RxIdle,
        RxStart,  // waiting for the middle of the start bit
        RxData,
        RxStop
    } rxState_t;

    rxState_t        state;
    logic            rxSync;
    logic [CntW-1:0] bitCnt;
    logic [2:0]      bitIdx;
    logic [7:0]      shiftReg;
    logic            tick;

    // single sync flop, line idles high
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxSync <= 1'b1;
        end else begin
            rxSync <= Rx;
        end
    end

    assign tick = (bitCnt == '0);

    // half a bit after the start edge, then one tick per bit
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            bitCnt <= HalfBit;
        end else if (state == RxIdle) begin
            bitCnt <= HalfBit;
        end else if (tick) begin
            bitCnt <= FullBit;
        end else begin
            bitCnt <= bitCnt - 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            state  <= RxIdle;
            bitIdx <= '0;
        end else begin
            case (state)
                RxIdle: begin
                    bitIdx <= '0;
                    if (!rxSync) state <= RxStart;
                end
                RxStart: begin
                    if (tick) state <= RxData;
                end
                RxData: begin
                    if (tick) begin
                        bitIdx <= bitIdx + 1'b1;
                        if (bitIdx == 3'd7) state <= RxStop;
                    end
                end
                RxStop: begin
                    if (tick) state <= RxIdle;  // stop bit level is not checked
                end
                default: state <= RxIdle;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge CLK) begin
        if (state == RxData && tick) shiftReg <= {rxSync, shiftReg[7:1]};
    end

    assign lineStart = (state == RxIdle) && !rxSync;
    assign rxByte    = '{strobe: (state == RxStop) && tick, data: shiftReg};

endmodule

// ==== hw/wordPacker.sv ====
module wordPacker (
    input  logic                                   CLK,
    input  logic                                   resetn,
    input  cfgLoaderPkg::byteEvt_t                 dataByte,
    input  logic                                   frameStart,
    output logic [cfgLoaderPkg::WORD_BYTES*8-1:0]  WriteData,
    output logic                                   WriteStrobe
);

    import cfgLoaderPkg::*;

    localparam int LaneW = (WORD_BYTES > 1) ? $clog2(WORD_BYTES) : 1;
    localparam logic [LaneW-1:0] LastLane = LaneW'(WORD_BYTES - 1);

    logic [LaneW-1:0] laneIdx;  // 0 is the most significant byte
    logic             wordDone;

    assign wordDone = dataByte.strobe && (laneIdx == LastLane);

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            laneIdx   <= '0;
            WriteData <= '0;
        end else if (frameStart) begin
            laneIdx   <= '0;  // leftovers of the last frame are dropped
            WriteData <= '0;
        end else if (dataByte.strobe) begin
            WriteData[8*(LastLane - laneIdx) +: 8] <= dataByte.data;
            laneIdx <= wordDone ? '0 : laneIdx + 1'b1;
        end
    end

    // pulse together with the last lane landing in WriteData
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            WriteStrobe <= 1'b0;
        end else begin
            WriteStrobe <= wordDone && !frameStart;
        end
    end

endmodule

// ==== tests/clkGen.sv ====
module clkGen #(
    parameter int Period      = 20,
    parameter int ResetCycles = 16
) (
    output logic CLK,
    output logic resetn
);

    initial begin
        CLK = 1'b0;
        forever #(Period / 2) CLK = ~CLK;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (ResetCycles) @(posedge CLK);
        @(negedge CLK);
        resetn = 1'b1;
    end

endmodule

// ==== tests/tbConfigLoader.sv ====
module tbConfigLoader;

    import cfgLoaderPkg::*;

    localparam int ComRate       = 16;
    localparam int TimeoutCycles = 600;
    localparam int MaxGap        = 250;  // byte spacing stays well under the timeout

    logic        CLK;
    logic        resetn;
    logic        Rx;
    logic [31:0] WriteData;
    logic        WriteStrobe;
    logic        ComActive;
    logic [7:0]  Command;

    logic [31:0] expQ[$];  // words predicted by the model
    logic [7:0]  txQ[$];   // payload bytes of the next frame as they go on the line
    string       testName;
    int          checks;
    int          mismatches;
    int          otherErrors;
    logic        sawActive;

    clkGen #(.Period(20), .ResetCycles(16)) uClk (.CLK(CLK), .resetn(resetn));

    configLoader #(.ComRate(ComRate), .TimeoutCycles(TimeoutCycles)) DUT (
        .CLK         (CLK),
        .resetn      (resetn),
        .Rx          (Rx),
        .WriteData   (WriteData),
        .WriteStrobe (WriteStrobe),
        .ComActive   (ComActive),
        .Command     (Command)
    );

    task automatic reportFailure(input string msg);
        otherErrors++;
        $display("ERROR in %s: %s", testName, msg);
    endtask

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            mismatches++;
            $display("CHECK FAILED %s: %s expected %h, actual %h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic confirm(input logic cond, input string msg);
        checks++;
        assert (cond) else reportFailure(msg);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(negedge CLK);
    endtask

    task automatic waitReset();
        int waited;
        waited = 0;
        while (!resetn && waited < 100) begin
            idleCycles(1);
            waited++;
        end
        confirm(resetn, "reset was never released");
    endtask

    // 8N1, LSB first, every bit ComRate cycles long
    task automatic sendByte(input logic [7:0] b);
        Rx = 1'b0;
        idleCycles(ComRate);
        for (int i = 0; i < 8; i++) begin
            Rx = b[i];
            idleCycles(ComRate);
        end
        Rx = 1'b1;  // stop bit, then idle
        idleCycles(ComRate);
    endtask

    function automatic int randomGap();
        return int'($urandom % MaxGap);
    endfunction

    function automatic logic [7:0] hexChar(input logic [3:0] nib, input logic upper);
        if (nib < 4'd10) return 8'h30 + 8'(nib);
        return (upper ? 8'h41 : 8'h61) + 8'(nib) - 8'd10;
    endfunction

    // neighbours of the hex ranges plus a few obvious ones
    function automatic logic [7:0] junkChar();
        logic [7:0] junk [8];
        junk = '{8'h2F, 8'h3A, 8'h40, 8'h47, 8'h60, 8'h67, 8'h7A, 8'h20};
        return junk[$urandom % 8];
    endfunction

    function automatic int nibbleOf(input logic [7:0] ch);
        if (ch inside {[8'h30:8'h39]}) return int'(ch) - 48;
        if (ch inside {[8'h41:8'h46]}) return int'(ch) - 55;
        if (ch inside {[8'h61:8'h66]}) return int'(ch) - 87;
        return -1;  // not a hex digit
    endfunction

    function automatic logic headerAccepted(input logic [23:0] id, input logic [7:0] cmd);
        return (id == SYNC_ID) && (cmd[6:0] inside {CMD_LOAD_A, CMD_LOAD_B});
    endfunction

    task automatic fillBinary(input int nBytes);
        txQ.delete();
        repeat (nBytes) txQ.push_back(8'($urandom));
    endtask

    task automatic fillHex(input int nBytes);
        logic [7:0] b;
        txQ.delete();
        for (int i = 0; i < nBytes; i++) begin
            b = 8'($urandom);
            if ($urandom % 3 == 0) txQ.push_back(junkChar());
            if ($urandom % 6 == 0) begin
                txQ.push_back(hexChar(4'($urandom), $urandom % 2 == 1));  // orphan half byte
                txQ.push_back(junkChar());
            end
            txQ.push_back(hexChar(b[7:4], $urandom % 2 == 1));
            txQ.push_back(hexChar(b[3:0], $urandom % 2 == 1));
        end
    endtask

    // decode txQ and queue only the complete words, MSB first
    task automatic predictWords(input logic hex);
        logic [7:0]  decoded[$];
        logic [31:0] word;
        int          hi;
        int          nib;
        hi = -1;
        foreach (txQ[i]) begin
            if (!hex) begin
                decoded.push_back(txQ[i]);
            end else begin
                nib = nibbleOf(txQ[i]);
                if (nib < 0) begin
                    hi = -1;
                end else if (hi < 0) begin
                    hi = nib;
                end else begin
                    decoded.push_back(8'(hi * 16 + nib));
                    hi = -1;
                end
            end
        end
        for (int i = 0; i + 4 <= decoded.size(); i += 4) begin
            word = {decoded[i], decoded[i + 1], decoded[i + 2], decoded[i + 3]};
            expQ.push_back(word);
        end
    endtask

    task automatic sendFrame(input logic [23:0] id, input logic [7:0] cmd);
        logic accepted;
        int   waited;
        accepted  = headerAccepted(id, cmd);
        sawActive = 1'b0;
        if (accepted) predictWords(cmd[HEX_MODE_BIT]);
        sendByte(id[23:16]);
        idleCycles(randomGap());
        sendByte(id[15:8]);
        idleCycles(randomGap());
        sendByte(id[7:0]);
        idleCycles(randomGap());
        sendByte(cmd);
        if (accepted) begin
            waited = 0;
            while (!ComActive && waited < ComRate) begin
                idleCycles(1);
                waited++;
            end
            confirm(ComActive, "ComActive did not rise after an accepted header");
            compareValue("Command", 32'(cmd), 32'(Command));
            foreach (txQ[i]) begin
                idleCycles(randomGap());
                sendByte(txQ[i]);
                confirm(ComActive, "ComActive dropped during the payload");
            end
            // the line stays quiet past the timeout to end the frame
            waited = 0;
            while (ComActive && waited < TimeoutCycles + ComRate) begin
                idleCycles(1);
                waited++;
            end
            confirm(!ComActive, "ComActive still high one bit time past the timeout");
            idleCycles(ComRate);
        end else begin
            // payload after a rejected header must never become words
            foreach (txQ[i]) begin
                idleCycles(randomGap());
                sendByte(txQ[i]);
            end
            idleCycles(TimeoutCycles + ComRate);
            confirm(!sawActive, "ComActive rose for a rejected header");
        end
        confirm(expQ.size() == 0, "predicted words were never written");
        expQ.delete();
    endtask

    // outputs sampled on the falling edge, half a cycle after they change
    always @(negedge CLK) begin
        logic [31:0] expWord;
        if (resetn) begin
            if (ComActive) sawActive = 1'b1;
            if (WriteStrobe) begin
                assert (expQ.size() != 0) else
                    reportFailure($sformatf("unexpected WriteStrobe with data %h", WriteData));
                if (expQ.size() != 0) begin
                    expWord = expQ.pop_front();
                    compareValue("WriteData", expWord, WriteData);
                end
            end
        end
    end

    initial begin
        logic [7:0] cmd;
        int         nBytes;
        Rx          = 1'b1;
        checks      = 0;
        mismatches  = 0;
        otherErrors = 0;
        sawActive   = 1'b0;
        testName    = "reset";
        void'($urandom(32'h0d3e_8e9f));

        waitReset();
        idleCycles(ComRate);
        compareValue("WriteData", 32'h0, WriteData);
        compareValue("Command", 32'h0, 32'(Command));
        confirm(!ComActive && !WriteStrobe, "outputs active after reset");

        testName = "binary frame";
        fillBinary(4 * (3 + int'($urandom % 4)));
        sendFrame(SYNC_ID, 8'h01);

        testName = "hex frame";
        fillHex(4 * (3 + int'($urandom % 3)));
        sendFrame(SYNC_ID, 8'h82);

        testName = "rejected id";
        fillBinary(8);
        sendFrame(24'h00ABFF, 8'h01);

        testName = "rejected command";
        fillBinary(6);  // leaves a second header half received
        sendFrame(SYNC_ID, 8'h05);

        testName = "frame after timeout";
        fillBinary(8);
        sendFrame(SYNC_ID, 8'h02);

        // leftover bytes must not leak into the next frame
        testName = "incomplete word";
        fillBinary(4 * (1 + int'($urandom % 3)) + 1 + int'($urandom % 3));
        sendFrame(SYNC_ID, 8'h01);
        testName = "hex after incomplete word";
        fillHex(4 * 2 + 3);
        sendFrame(SYNC_ID, 8'h81);
        testName = "binary after incomplete word";
        fillBinary(12);
        sendFrame(SYNC_ID, 8'h02);

        for (int n = 0; n < 3; n++) begin
            testName = $sformatf("random frame %0d", n);
            cmd      = {1'($urandom % 2), 7'(1 + $urandom % 2)};
            nBytes   = 1 + int'($urandom % 14);
            if (cmd[HEX_MODE_BIT]) fillHex(nBytes);
            else fillBinary(nBytes);
            sendFrame(SYNC_ID, cmd);
        end

        $display("checks %0d, value mismatches %0d, other errors %0d",
                 checks, mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
